//--- mdio_cmd_fifo.sv
// MDIO command FIFO
// four-entry queue of register/data write commands between
// the init sequencer and the MDIO master
`timescale 1ns/10ps

module mdio_cmd_fifo (
    input  logic                                  clk_125mhz_int,
    input  logic                                  rst_125mhz_int,
    input  logic                                  wr_i,
    input  logic [mdio_init_pkg::MDIO_REG_W-1:0]  wr_reg_i,
    input  logic [mdio_init_pkg::MDIO_DATA_W-1:0] wr_data_i,
    input  logic                                  rd_i,
    output logic [mdio_init_pkg::MDIO_REG_W-1:0]  rd_reg_o,
    output logic [mdio_init_pkg::MDIO_DATA_W-1:0] rd_data_o,
    output logic                                  full_o,
    output logic                                  empty_o
);
    import mdio_init_pkg::*;

    logic [MDIO_CMD_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  push;
    logic                  pop;

    assign push = wr_i && !full_o;
    assign pop  = rd_i && !empty_o;

    assign full_o  = (int'(count) == FIFO_DEPTH);
    assign empty_o = (count == '0);

    // head entry, valid while not empty
    assign rd_reg_o  = mem[rd_ptr][MDIO_CMD_W-1:MDIO_DATA_W];
    assign rd_data_o = mem[rd_ptr][MDIO_DATA_W-1:0];

    always_ff @(posedge clk_125mhz_int) begin
        if (push) begin
            mem[wr_ptr] <= {wr_reg_i, wr_data_i};
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- mdio_init_pkg.sv
// MDIO init package
// shared widths, PHY register map, extended register table,
// start-up timing and the state and opcode types
package mdio_init_pkg;

    localparam int MDIO_REG_W  = 5;
    localparam int MDIO_DATA_W = 16;
    localparam int MDIO_CMD_W  = MDIO_REG_W + MDIO_DATA_W;

    localparam logic [MDIO_REG_W-1:0] PHY_ADDR  = 5'd3;
    localparam logic [MDIO_REG_W-1:0] REG_REGCR = 5'h0D;
    localparam logic [MDIO_REG_W-1:0] REG_ADDAR = 5'h0E;

    // REGCR function codes, devad 0x1f
    localparam logic [MDIO_DATA_W-1:0] REGCR_FN_ADDR = 16'h001F;
    localparam logic [MDIO_DATA_W-1:0] REGCR_FN_DATA = 16'h401F;

    // CFG4, SGMIICTL1, 10M_SGMII_CFG
    localparam int EXT_REG_COUNT = 3;
    localparam logic [MDIO_DATA_W-1:0] EXT_REG_ADDR [EXT_REG_COUNT] =
        '{16'h0031, 16'h00D3, 16'h016F};
    localparam logic [MDIO_DATA_W-1:0] EXT_REG_DATA [EXT_REG_COUNT] =
        '{16'h0070, 16'h4000, 16'h0015};

    localparam int STARTUP_DELAY_CYCLES = 1024;
    // mdc holds each level for MDC_PRESCALE+1 clocks
    localparam int MDC_PRESCALE  = 3;
    localparam int PREAMBLE_BITS = 32;
    localparam int FRAME_BITS    = 64;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;

    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_t;

    typedef enum logic [1:0] {
        SEQ_DELAY,
        SEQ_ISSUE,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        MDIO_IDLE,
        MDIO_LOAD,
        MDIO_SHIFT
    } mdio_state_t;

endpackage

//--- mdio_write_master.sv
// MDIO write master
// pops one command at a time and shifts out a clause-22 write frame
// on MDC/MDIO, with MDC divided down from the management clock
`timescale 1ns/10ps

module mdio_write_master (
    input  logic                                  clk_125mhz_int,
    input  logic                                  rst_125mhz_int,
    input  logic                                  cmd_empty_i,
    input  logic [mdio_init_pkg::MDIO_REG_W-1:0]  cmd_reg_i,
    input  logic [mdio_init_pkg::MDIO_DATA_W-1:0] cmd_data_i,
    output logic                                  cmd_rd_o,
    output logic                                  busy_o,
    output logic                                  mdc_o,
    output logic                                  mdio_o,
    output logic                                  mdio_t_o
);
    import mdio_init_pkg::*;

    mdio_state_t                          state;
    logic [$clog2(MDC_PRESCALE+1)-1:0]    presc_cnt;
    logic [$clog2(FRAME_BITS)-1:0]        bit_cnt;
    logic [FRAME_BITS-1:0]                shift_reg;
    logic [FRAME_BITS-1:0]                frame_word;
    logic                                 presc_wrap;
    logic                                 mdc_fall;
    logic                                 bit_next;
    logic                                 last_bit;

    // preamble, start, opcode, phy, reg, turnaround, data
    assign frame_word = {{PREAMBLE_BITS{1'b1}}, 2'b01, MDIO_OP_WRITE, PHY_ADDR,
                         cmd_reg_i, 2'b10, cmd_data_i};

    assign cmd_rd_o = (state == MDIO_LOAD) && !cmd_empty_i;
    assign busy_o   = (state != MDIO_IDLE);

    assign presc_wrap = (int'(presc_cnt) == MDC_PRESCALE);
    assign mdc_fall   = presc_wrap && mdc_o;
    assign last_bit   = (int'(bit_cnt) == FRAME_BITS - 1);

    // first clock after a falling edge, except at frame start
    assign bit_next = (state == MDIO_SHIFT) && (presc_cnt == '0) && !mdc_o &&
                      (bit_cnt != '0);

    always_ff @(posedge clk_125mhz_int) begin
        if (cmd_rd_o) begin
            shift_reg <= frame_word;
        end else if (bit_next) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state     <= MDIO_IDLE;
            presc_cnt <= '0;
            bit_cnt   <= '0;
            mdc_o     <= 1'b0;
            mdio_o    <= 1'b1;
            mdio_t_o  <= 1'b1;
        end else begin
            case (state)
                MDIO_IDLE: begin
                    if (!cmd_empty_i) begin
                        state <= MDIO_LOAD;
                    end
                end
                MDIO_LOAD: begin
                    if (cmd_rd_o) begin
                        state     <= MDIO_SHIFT;
                        presc_cnt <= '0;
                        bit_cnt   <= '0;
                        mdc_o     <= 1'b0;
                        mdio_o    <= frame_word[FRAME_BITS-1];
                        mdio_t_o  <= 1'b0;
                    end else begin
                        state <= MDIO_IDLE;
                    end
                end
                MDIO_SHIFT: begin
                    if (presc_wrap) begin
                        presc_cnt <= '0;
                        mdc_o     <= !mdc_o;
                    end else begin
                        presc_cnt <= presc_cnt + 1'b1;
                    end
                    // shift_reg[msb] still holds the bit just sent
                    if (bit_next) begin
                        mdio_o <= shift_reg[FRAME_BITS-2];
                    end
                    // a falling edge closes each bit period
                    if (mdc_fall) begin
                        if (last_bit) begin
                            state    <= MDIO_IDLE;
                            mdio_o   <= 1'b1;
                            mdio_t_o <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= MDIO_IDLE;
                end
            endcase
        end
    end

endmodule

//--- phy_init_sequencer.sv
// PHY init sequencer
// waits out the settling delay, then expands each extended register
// into four REGCR/ADDAR writes and queues them for the MDIO master
`timescale 1ns/10ps

module phy_init_sequencer (
    input  logic                                  clk_125mhz_int,
    input  logic                                  rst_125mhz_int,
    input  logic                                  fifo_full_i,
    input  logic                                  fifo_empty_i,
    input  logic                                  mdio_busy_i,
    output logic                                  cmd_wr_o,
    output logic [mdio_init_pkg::MDIO_REG_W-1:0]  cmd_reg_o,
    output logic [mdio_init_pkg::MDIO_DATA_W-1:0] cmd_data_o,
    output logic                                  init_done_o
);
    import mdio_init_pkg::*;

    seq_state_t                                state;
    logic [$clog2(STARTUP_DELAY_CYCLES)-1:0]   delay_cnt;
    logic [$clog2(EXT_REG_COUNT)-1:0]          entry_idx;
    logic [1:0]                                phase;
    logic                                      last_write;

    // final ADDAR data write of the last table entry
    assign last_write = (int'(entry_idx) == EXT_REG_COUNT - 1) && (phase == 2'd3);

    // held off while the fifo is full
    assign cmd_wr_o = (state == SEQ_ISSUE) && !fifo_full_i;

    assign init_done_o = (state == SEQ_DONE);

    // indirect access pattern for one extended register
    always_comb begin
        case (phase)
            2'd0: begin
                cmd_reg_o  = REG_REGCR;
                cmd_data_o = REGCR_FN_ADDR;
            end
            2'd1: begin
                cmd_reg_o  = REG_ADDAR;
                cmd_data_o = EXT_REG_ADDR[entry_idx];
            end
            2'd2: begin
                cmd_reg_o  = REG_REGCR;
                cmd_data_o = REGCR_FN_DATA;
            end
            default: begin
                cmd_reg_o  = REG_ADDAR;
                cmd_data_o = EXT_REG_DATA[entry_idx];
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state     <= SEQ_DELAY;
            delay_cnt <= ($clog2(STARTUP_DELAY_CYCLES))'(STARTUP_DELAY_CYCLES - 1);
            entry_idx <= '0;
            phase     <= '0;
        end else begin
            case (state)
                SEQ_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= SEQ_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                SEQ_ISSUE: begin
                    if (cmd_wr_o) begin
                        phase <= phase + 2'd1;
                        if (last_write) begin
                            state <= SEQ_DRAIN;
                        end else if (phase == 2'd3) begin
                            entry_idx <= entry_idx + 1'b1;
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // last frame is out once the fifo is empty and the master idle
                    if (fifo_empty_i && !mdio_busy_i) begin
                        state <= SEQ_DONE;
                    end
                end
                default: begin
                    state <= SEQ_DONE;
                end
            endcase
        end
    end

endmodule

//--- phy_mgmt_testdata.txt
// expected MDIO write frames in order, one frame per line
// columns: register address (hex), register data (hex)
0d 001f
0e 0031
0d 401f
0e 0070
0d 001f
0e 00d3
0d 401f
0e 4000
0d 001f
0e 016f
0d 401f
0e 0015

//--- phy_mgmt_top.sv
// PHY management top level
// start-up configuration of the ethernet PHY over MDIO:
// sequencer, command FIFO and MDIO write master
`timescale 1ns/10ps

module phy_mgmt_top (
    input  logic clk_125mhz_int,
    input  logic rst_125mhz_int,
    output logic mdc_o,
    output logic mdio_o,
    output logic mdio_t_o,
    output logic init_done_o
);
    import mdio_init_pkg::*;

    logic                   cmd_wr;
    logic [MDIO_REG_W-1:0]  cmd_reg;
    logic [MDIO_DATA_W-1:0] cmd_data;
    logic                   cmd_rd;
    logic [MDIO_REG_W-1:0]  head_reg;
    logic [MDIO_DATA_W-1:0] head_data;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   mdio_busy;

    phy_init_sequencer i_phy_init_sequencer (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .fifo_full_i    (fifo_full),
        .fifo_empty_i   (fifo_empty),
        .mdio_busy_i    (mdio_busy),
        .cmd_wr_o       (cmd_wr),
        .cmd_reg_o      (cmd_reg),
        .cmd_data_o     (cmd_data),
        .init_done_o    (init_done_o)
    );

    mdio_cmd_fifo i_mdio_cmd_fifo (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .wr_i           (cmd_wr),
        .wr_reg_i       (cmd_reg),
        .wr_data_i      (cmd_data),
        .rd_i           (cmd_rd),
        .rd_reg_o       (head_reg),
        .rd_data_o      (head_data),
        .full_o         (fifo_full),
        .empty_o        (fifo_empty)
    );

    mdio_write_master i_mdio_write_master (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_empty_i    (fifo_empty),
        .cmd_reg_i      (head_reg),
        .cmd_data_i     (head_data),
        .cmd_rd_o       (cmd_rd),
        .busy_o         (mdio_busy),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_t_o       (mdio_t_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the PHY management testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_phy_mgmt_top \
    -f verilog.f \
    -o sim_phy_mgmt

./obj_dir/sim_phy_mgmt > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb_phy_mgmt_top.sv
// PHY management testbench
// decodes the MDIO write frames of the start-up sequence, compares them
// with the expected register/data list and repeats after a reset mid-sequence
`timescale 1ns/10ps

module tb_phy_mgmt_top;
    import mdio_init_pkg::*;

    localparam int NUM_FRAMES     = 12;
    localparam int QUIET_CYCLES   = 2000;
    localparam int START_TIMEOUT  = 4 * STARTUP_DELAY_CYCLES;
    localparam int FRAMES_TIMEOUT = 20000;
    localparam int DONE_TIMEOUT   = 100;

    logic clk_125mhz_int;
    logic rst_125mhz_int;
    logic mdc;
    logic mdio;
    logic mdio_t;
    logic init_done;

    // even entries hold the register, odd entries the data
    logic [15:0] exp_mem [2*NUM_FRAMES];
    logic [7:0]  lfsr;

    logic                  mdc_prev;
    logic                  mdio_t_prev;
    logic                  done_prev;
    logic [FRAME_BITS-1:0] frame_word;
    int                    level_cnt;
    int                    bit_cnt;
    int                    frame_cnt;
    int                    mon_fmt;
    int                    mon_data;
    int                    fmt_err = 0;
    int                    data_err = 0;
    int                    mdc_err = 0;
    int                    done_err = 0;
    int                    main_err = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    bit                    timed_out = 1'b0;

    phy_mgmt_top i_phy_mgmt_top (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .mdc_o          (mdc),
        .mdio_o         (mdio),
        .mdio_t_o       (mdio_t),
        .init_done_o    (init_done)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    // taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int total_errors();
        return main_err + fmt_err + data_err + mdc_err + done_err;
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic report_timeout(input string msg);
        $display("%s", msg);
        timed_out = 1'b1;
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: passed", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errs);
            tests_failed++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_125mhz_int);
        rst_125mhz_int <= 1'b1;
        repeat (2) @(negedge clk_125mhz_int);
        rst_125mhz_int <= 1'b0;
    endtask

    task automatic check_frame(input logic [FRAME_BITS-1:0] w, input int idx, input int nbits,
                               output int n_fmt, output int n_data);
        n_fmt  = 0;
        n_data = 0;
        if (nbits != FRAME_BITS) begin
            $display("Error at %0t: frame %0d has %0d bits", $time, idx + 1, nbits);
            n_fmt++;
        end
        if (w[63:32] !== {PREAMBLE_BITS{1'b1}} || w[31:30] !== 2'b01 || w[29:28] !== 2'b01 ||
            w[27:23] !== PHY_ADDR || w[17:16] !== 2'b10) begin
            $display("Error at %0t: frame %0d has a bad header, word %h", $time, idx + 1, w);
            n_fmt++;
        end
        if (idx >= NUM_FRAMES) begin
            $display("Error at %0t: unexpected frame %0d", $time, idx + 1);
            n_data++;
        end else if (w[22:18] !== exp_mem[2*idx][4:0] || w[15:0] !== exp_mem[2*idx+1]) begin
            $display("Error at %0t: frame %0d reg %h data %h, expected reg %h data %h", $time,
                     idx + 1, w[22:18], w[15:0], exp_mem[2*idx][4:0], exp_mem[2*idx+1]);
            n_data++;
        end
    endtask

    // frame monitor, sampled between rising clock edges
    always @(negedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            level_cnt <= 0;
            bit_cnt   <= 0;
            frame_cnt <= 0;
        end else begin
            if (mdc != mdc_prev) begin
                if (!mdio_t_prev && level_cnt != 4) begin
                    $display("Error at %0t: MDC phase of %0d cycles", $time, level_cnt);
                    mdc_err <= mdc_err + 1;
                end else if (mdio_t_prev && mdio_t) begin
                    $display("Error at %0t: MDC edge outside a frame", $time);
                    mdc_err <= mdc_err + 1;
                end
                level_cnt <= 1;
            end else if (!mdio_t && mdio_t_prev) begin
                level_cnt <= 1;
            end else begin
                level_cnt <= level_cnt + 1;
            end
            // rising MDC edge inside a frame
            if (mdc && !mdc_prev && !mdio_t) begin
                frame_word <= {frame_word[FRAME_BITS-2:0], mdio};
                bit_cnt    <= bit_cnt + 1;
            end
            if (mdio_t && !mdio_t_prev) begin
                check_frame(frame_word, frame_cnt, bit_cnt, mon_fmt, mon_data);
                fmt_err   <= fmt_err + mon_fmt;
                data_err  <= data_err + mon_data;
                bit_cnt   <= 0;
                frame_cnt <= frame_cnt + 1;
            end
            if (init_done && !done_prev && frame_cnt < NUM_FRAMES) begin
                $display("Error at %0t: init_done high after %0d frames", $time, frame_cnt);
                done_err <= done_err + 1;
            end
        end
        mdc_prev    <= mdc;
        mdio_t_prev <= mdio_t;
        done_prev   <= init_done;
    end

    task automatic check_startup(output int errs);
        int cycles;
        errs = 0;
        if (mdc !== 1'b0 || mdio_t !== 1'b1 || init_done !== 1'b0) begin
            $display("Error at %0t: wrong state after reset, mdc %b mdio_t %b done %b",
                     $time, mdc, mdio_t, init_done);
            errs++;
        end
        cycles = 0;
        while (mdc !== 1'b1 && cycles < START_TIMEOUT) begin
            @(negedge clk_125mhz_int);
            cycles++;
        end
        if (mdc !== 1'b1) begin
            report_timeout("timeout: no MDC activity after reset");
        end else if (cycles <= STARTUP_DELAY_CYCLES) begin
            $display("Error at %0t: first MDC edge after only %0d cycles", $time, cycles);
            errs++;
        end
    endtask

    task automatic wait_for_frames(input int n);
        int cycles;
        cycles = 0;
        while (frame_cnt < n && cycles < FRAMES_TIMEOUT) begin
            @(negedge clk_125mhz_int);
            cycles++;
        end
        if (frame_cnt < n) begin
            report_timeout("timeout: fewer frames than expected on MDIO");
        end
    endtask

    task automatic check_completion(output int errs);
        int   cycles;
        logic quiet_ok;
        errs = 0;
        cycles = 0;
        while (init_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk_125mhz_int);
            cycles++;
        end
        if (init_done !== 1'b1) begin
            report_timeout("timeout: init_done did not rise after the last frame");
        end else begin
            quiet_ok = 1'b1;
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk_125mhz_int);
                if (quiet_ok && (mdc !== 1'b0 || mdio_t !== 1'b1 || init_done !== 1'b1)) begin
                    $display("Error at %0t: MDIO activity or init_done low after completion",
                             $time);
                    quiet_ok = 1'b0;
                    errs++;
                end
            end
        end
    endtask

    initial begin : main
        int errs;
        int snapshot;
        int fsel;
        int boff;
        int cycles;
        rst_125mhz_int = 1'b1;
        lfsr = 8'd39;
        $readmemh("phy_mgmt_testdata.txt", exp_mem);

        apply_reset();
        check_startup(errs);
        main_err += errs;
        if (!timed_out) begin
            report_test(1, "reset state and startup delay", errs);
            wait_for_frames(NUM_FRAMES);
        end
        if (!timed_out) begin
            report_test(2, "frame format", fmt_err);
            report_test(3, "frame content and order", data_err);
            report_test(4, "MDC phase length", mdc_err);
            check_completion(errs);
            main_err += errs;
        end
        if (!timed_out) begin
            report_test(5, "completion", errs + done_err);

            // restart, then reset again inside a random frame
            snapshot = total_errors();
            apply_reset();
            draw_bits(4, fsel);
            fsel = 1 + fsel % 11;
            draw_bits(6, boff);
            $display("reset point: frame %0d, bit %0d", fsel, boff);
            cycles = 0;
            while (!(frame_cnt == fsel - 1 && bit_cnt > boff) && cycles < FRAMES_TIMEOUT) begin
                @(negedge clk_125mhz_int);
                cycles++;
            end
            if (!(frame_cnt == fsel - 1 && bit_cnt > boff)) begin
                report_timeout("timeout: reset point never reached");
            end
        end
        if (!timed_out) begin
            apply_reset();
            check_startup(errs);
            main_err += errs;
        end
        if (!timed_out) begin
            wait_for_frames(NUM_FRAMES);
        end
        if (!timed_out) begin
            check_completion(errs);
            main_err += errs;
        end
        if (!timed_out) begin
            report_test(6, "reset mid-sequence", total_errors() - snapshot);
        end

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, total_errors());
        if (!timed_out && tests_failed == 0 && total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
mdio_init_pkg.sv
mdio_cmd_fifo.sv
mdio_write_master.sv
phy_init_sequencer.sv
phy_mgmt_top.sv
tb_phy_mgmt_top.sv
